// ==== aluAxiRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluAxiRegs (
    input  logic                           clk,
    input  logic                           rst,
    // AXI4-Lite write address and data
    input  logic [aluPkg::addrWidth-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [aluPkg::dataWidth-1:0]   wdata,
    input  logic [aluPkg::dataWidth/8-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    // AXI4-Lite read
    input  logic [aluPkg::addrWidth-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [aluPkg::dataWidth-1:0]   rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    // Pipeline side
    output logic                           issueValid,
    output aluPkg::issueT                  issueItem,
    input  logic [aluPkg::dataWidth-1:0]   result,
    input  aluPkg::flagsT                  flags,
    input  logic [7:0]                     doneCount
);
    import aluPkg::*;

    logic                 wrReady;
    logic                 wrAccept;
    logic                 rdAccept;
    logic                 regWrite;
    logic [dataWidth-1:0] opAReg;
    logic [dataWidth-1:0] opBReg;
    logic [opWidth-1:0]   lastOp;
    logic [dataWidth-1:0] readMux;

    assign awready  = wrReady;       // AW and W taken together
    assign wready   = wrReady;
    assign wrAccept = wrReady & awvalid & wvalid;
    assign rdAccept = arready & arvalid;
    assign regWrite = wrAccept & (&wstrb);   // Partial strobes ignored
    assign bresp    = 2'b00;
    assign rresp    = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrReady <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // One-cycle ready pulse once both channels are valid
            wrReady <= awvalid & wvalid & ~bvalid & ~wrReady;
            if (wrAccept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opAReg     <= '0;
            opBReg     <= '0;
            lastOp     <= '0;
            issueValid <= 1'b0;
        end else begin
            issueValid <= regWrite && (awaddr == regCtrl);
            if (regWrite) begin
                case (awaddr)
                    regOpA:  opAReg <= wdata;
                    regOpB:  opBReg <= wdata;
                    regCtrl: lastOp <= wdata[opWidth-1:0];
                    default: ;      // Result, status and holes are read-only
                endcase
            end
        end
    end

    // Snapshot of the operands at the control write
    always_ff @(posedge clk) begin
        if (regWrite && (awaddr == regCtrl)) begin
            issueItem.opA <= opAReg;
            issueItem.opB <= opBReg;
            issueItem.op  <= wdata[opWidth-1:0];
        end
    end

    always_comb begin
        case (araddr)
            regOpA:    readMux = opAReg;
            regOpB:    readMux = opBReg;
            regCtrl:   readMux = {{(dataWidth-opWidth){1'b0}}, lastOp};
            regResult: readMux = result;
            regStatus: readMux = {{(dataWidth-16){1'b0}}, doneCount, 3'b000, flags};
            default:   readMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ~rvalid & ~rdAccept;   // Blocked while R is held
            if (rdAccept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= readMux;   // Stable until rready
        end
    end

endmodule

`default_nettype wire

// ==== aluDecodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecodeStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  aluPkg::issueT   inItem,
    output logic            outValid,
    output aluPkg::decodedT outItem
);
    import aluPkg::*;

    decodedT decoded;

    always_comb begin
        decoded.opA       = inItem.opA;
        decoded.opB       = inItem.opB;
        decoded.op        = inItem.op;
        decoded.unit      = unitNone;
        decoded.subtract  = 1'b0;
        decoded.signedCmp = 1'b0;
        decoded.illegal   = 1'b0;
        case (inItem.op)
            opAdd: decoded.unit = unitAdder;
            opSub: begin
                decoded.unit     = unitAdder;
                decoded.subtract = 1'b1;
            end
            opAnd, opOr, opXor: decoded.unit = unitLogic;
            opSll, opSrl, opSra: decoded.unit = unitShift;
            opSlt: begin
                decoded.unit      = unitCompare;
                decoded.subtract  = 1'b1;     // Compare on A - B
                decoded.signedCmp = 1'b1;
            end
            opSltu: begin
                decoded.unit     = unitCompare;
                decoded.subtract = 1'b1;
            end
            default: decoded.illegal = 1'b1;  // 0xA to 0xF
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (inValid) begin
            outItem <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== aluExecuteStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecuteStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  aluPkg::decodedT inItem,
    output logic            outValid,
    output aluPkg::execT    outItem
);
    import aluPkg::*;

    logic [dataWidth-1:0] adderSum;
    logic                 adderCarryOut;
    logic                 adderOverflow;
    logic [dataWidth-1:0] logicResult;
    logic [dataWidth-1:0] shiftResult;
    logic [dataWidth-1:0] cmpResult;
    logic [dataWidth-1:0] unitResult;
    logic [4:0]           shamt;
    logic                 lessThan;
    logic                 isArith;
    execT                 executed;

    claAdder adderInst (
        .a        (inItem.opA),
        .b        (inItem.opB),
        .subtract (inItem.subtract),
        .sum      (adderSum),
        .carryOut (adderCarryOut),
        .overflow (adderOverflow)
    );

    assign shamt = inItem.opB[4:0];

    always_comb begin
        case (inItem.op)
            opAnd:   logicResult = inItem.opA & inItem.opB;
            opOr:    logicResult = inItem.opA | inItem.opB;
            default: logicResult = inItem.opA ^ inItem.opB;
        endcase
    end

    always_comb begin
        case (inItem.op)
            opSll:   shiftResult = inItem.opA << shamt;
            opSrl:   shiftResult = inItem.opA >> shamt;
            default: shiftResult = $signed(inItem.opA) >>> shamt; // SRA, sign fill
        endcase
    end

    // Signed: sign of difference corrected by overflow
    // Unsigned: borrow out of A - B
    assign lessThan  = inItem.signedCmp ? (adderSum[dataWidth-1] ^ adderOverflow)
                                        : ~adderCarryOut;
    assign cmpResult = {{(dataWidth-1){1'b0}}, lessThan};
    assign isArith   = (inItem.op == opAdd) || (inItem.op == opSub);

    always_comb begin
        case (inItem.unit)
            unitAdder:   unitResult = adderSum;
            unitLogic:   unitResult = logicResult;
            unitShift:   unitResult = shiftResult;
            unitCompare: unitResult = cmpResult;
            default:     unitResult = '0;   // Illegal op
        endcase
    end

    always_comb begin
        executed.result        = unitResult;
        // Carry flag sense: inverted carry-out when subtracting
        executed.adderCarry    = adderCarryOut ^ inItem.subtract;
        executed.adderOverflow = adderOverflow;
        executed.flagArith     = isArith;
        executed.illegal       = inItem.illegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            outItem <= executed;
        end
    end

endmodule

`default_nettype wire

// ==== aluFlagStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluFlagStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inValid,
    input  aluPkg::execT                 inItem,
    output logic                         outValid,
    output logic [aluPkg::dataWidth-1:0] result,
    output aluPkg::flagsT                flags,
    output logic [7:0]                   doneCount
);
    import aluPkg::*;

    flagsT nextFlags;

    always_comb begin
        nextFlags.zero     = (inItem.result == '0);
        nextFlags.negative = inItem.result[dataWidth-1];
        // Only ADD and SUB report carry and overflow
        nextFlags.carry    = inItem.flagArith & inItem.adderCarry;
        nextFlags.overflow = inItem.flagArith & inItem.adderOverflow;
        nextFlags.illegal  = inItem.illegal;
    end

    // Result and flags hold until the next completion
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid  <= 1'b0;
            result    <= '0;
            flags     <= '0;
            doneCount <= '0;
        end else begin
            outValid <= inValid;
            if (inValid) begin
                result    <= inItem.result;
                flags     <= nextFlags;
                doneCount <= doneCount + 8'd1;   // Wraps at 256
            end
        end
    end

endmodule

`default_nettype wire

// ==== aluPkg.sv ====
`default_nettype none

package aluPkg;

    // Datapath and bus widths
    localparam int dataWidth = 32;
    localparam int opWidth   = 4;
    localparam int addrWidth = 5;

    // Register byte addresses
    localparam logic [addrWidth-1:0] regOpA    = 5'h00;
    localparam logic [addrWidth-1:0] regOpB    = 5'h04;
    localparam logic [addrWidth-1:0] regCtrl   = 5'h08; // Opcode in bits 3:0
    localparam logic [addrWidth-1:0] regResult = 5'h0C;
    localparam logic [addrWidth-1:0] regStatus = 5'h10; // Flags 4:0, count 15:8

    // Opcodes
    localparam logic [opWidth-1:0] opAnd  = 4'h0;
    localparam logic [opWidth-1:0] opOr   = 4'h1;
    localparam logic [opWidth-1:0] opAdd  = 4'h2;
    localparam logic [opWidth-1:0] opXor  = 4'h3;
    localparam logic [opWidth-1:0] opSll  = 4'h4;
    localparam logic [opWidth-1:0] opSrl  = 4'h5;
    localparam logic [opWidth-1:0] opSub  = 4'h6;
    localparam logic [opWidth-1:0] opSra  = 4'h7;
    localparam logic [opWidth-1:0] opSlt  = 4'h8;
    localparam logic [opWidth-1:0] opSltu = 4'h9;

    typedef struct packed {
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [opWidth-1:0]   op;
    } issueT;

    typedef enum logic [2:0] {
        unitNone,
        unitAdder,
        unitLogic,
        unitShift,
        unitCompare
    } unitT;

    typedef struct packed {
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [opWidth-1:0]   op;
        unitT                 unit;
        logic                 subtract;  // Adder inverts B, carry-in set
        logic                 signedCmp;
        logic                 illegal;
    } decodedT;

    typedef struct packed {
        logic [dataWidth-1:0] result;
        logic                 adderCarry;
        logic                 adderOverflow;
        logic                 flagArith; // ADD or SUB
        logic                 illegal;
    } execT;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
        logic illegal;
    } flagsT;

endpackage

`default_nettype wire

// ==== aluTop.f ====
aluPkg.sv
claAdder.sv
aluDecodeStage.sv
aluExecuteStage.sv
aluFlagStage.sv
aluAxiRegs.sv
aluTop.sv
aluTop_checker.sv
aluTop_tb.sv

// ==== aluTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [aluPkg::addrWidth-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [aluPkg::dataWidth-1:0]   wdata,
    input  logic [aluPkg::dataWidth/8-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [aluPkg::addrWidth-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [aluPkg::dataWidth-1:0]   rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready
);
    import aluPkg::*;

    logic                 issueValid;
    issueT                issueItem;
    logic                 decValid;
    decodedT              decItem;
    logic                 exeValid;
    execT                 exeItem;
    logic                 flagValid;   // Completion strobe, watched by the checker
    logic [dataWidth-1:0] result;
    flagsT                flags;
    logic [7:0]           doneCount;

    aluAxiRegs regsInst (
        .clk, .rst,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .issueValid, .issueItem,
        .result, .flags, .doneCount
    );

    aluDecodeStage decodeInst (
        .clk, .rst,
        .inValid (issueValid), .inItem (issueItem),
        .outValid (decValid), .outItem (decItem)
    );

    aluExecuteStage executeInst (
        .clk, .rst,
        .inValid (decValid), .inItem (decItem),
        .outValid (exeValid), .outItem (exeItem)
    );

    aluFlagStage flagInst (
        .clk, .rst,
        .inValid (exeValid), .inItem (exeItem),
        .outValid (flagValid),
        .result, .flags, .doneCount
    );

endmodule

`default_nettype wire

// ==== aluTop_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         awready,
    input logic                         wready,
    input logic                         bvalid,
    input logic                         bready,
    input logic                         arready,
    input logic                         rvalid,
    input logic                         rready,
    input logic [aluPkg::dataWidth-1:0] rdata,
    input logic                         issueValid,
    input logic                         flagValid
);
    int failCount = 0;   // Read by the testbench at the end

    // B response held until bready
    bHold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        failCount++;
    end

    rHold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        failCount++;
    end

    // Second reset cycle onward, all handshake and pipeline valids low
    quietInReset: assert property (@(posedge clk)
        rst && $past(rst) |-> !(awready || wready || bvalid || arready || rvalid
                                || issueValid || flagValid))
    else begin
        $error("Handshake or valid output high during reset");
        failCount++;
    end

    issueToDone: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> ##3 flagValid)
    else begin
        $error("No flag stage output 3 cycles after issue");
        failCount++;
    end

endmodule

bind aluTop aluTop_checker checkerInst (
    .clk        (clk),
    .rst        (rst),
    .awready    (awready),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .issueValid (issueValid),
    .flagValid  (flagValid)
);

`default_nettype wire

// ==== aluTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop_tb;
    import aluPkg::*;

    logic                   clk;
    logic                   rst;
    logic [addrWidth-1:0]   awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [dataWidth-1:0]   wdata;
    logic [dataWidth/8-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [addrWidth-1:0]   araddr;
    logic                   arvalid;
    logic                   arready;
    logic [dataWidth-1:0]   rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    int          errors;
    int          timeouts;
    logic [31:0] seed;
    logic [7:0]  expCount;     // Expected completion count
    logic [31:0] lastResult;
    logic [31:0] edgeVals [0:5] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF,
                                    32'h1F, 32'h1};

    aluTop aluTop_inst (
        .clk, .rst,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    always #4 clk = ~clk;

    function logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Returns {zero, negative, carry, overflow, illegal, result}
    function automatic logic [36:0] referenceAlu(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [3:0] op);
        logic [32:0] wide;
        logic [31:0] res;
        logic        carry;
        logic        ovf;
        logic        ill;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        ill   = 1'b0;
        case (op)
            opAnd:  res = a & b;
            opOr:   res = a | b;
            opXor:  res = a ^ b;
            opAdd: begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[31:0];
                carry = wide[32];
                ovf   = (a[31] == b[31]) && (res[31] != a[31]);
            end
            opSub: begin
                res   = a - b;
                carry = (a < b);   // Borrow
                ovf   = (a[31] != b[31]) && (res[31] != a[31]);
            end
            opSll:  res = a << b[4:0];
            opSrl:  res = a >> b[4:0];
            opSra:  res = $signed(a) >>> b[4:0];
            opSlt:  res = {31'h0, $signed(a) < $signed(b)};
            opSltu: res = {31'h0, a < b};
            default: ill = 1'b1;
        endcase
        return {res == 32'h0, res[31], carry, ovf, ill, res};
    endfunction

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [31:0] data);
        int cycles;
        cycles  = 0;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= '1;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!awready && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!awready) begin
            $display("Write to address 0x%02h was never accepted", addr);
            timeouts++;
            return;
        end
        cycles = 0;
        @(posedge clk);
        while (!bvalid && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (!bvalid) begin
            $display("No write response for address 0x%02h", addr);
            timeouts++;
            return;
        end
        compareWord("bresp", 32'h0, {30'h0, bresp});
        bready <= 1'b1;   // Response waits one cycle before it is taken
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic readReg(input logic [addrWidth-1:0] addr, output logic [31:0] data);
        int cycles;
        cycles  = 0;
        data    = '0;
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        arvalid <= 1'b0;
        if (!arready) begin
            $display("Read of address 0x%02h was never accepted", addr);
            timeouts++;
            return;
        end
        cycles = 0;
        @(posedge clk);
        while (!rvalid && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (!rvalid) begin
            $display("No read data for address 0x%02h", addr);
            timeouts++;
            return;
        end
        data = rdata;
        compareWord("rresp", 32'h0, {30'h0, rresp});
        rready <= 1'b1;   // Data held one cycle before it is taken
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Polls regStatus until the count reaches expCount
    task automatic waitDone(output logic [31:0] status);
        int polls;
        polls = 0;
        readReg(regStatus, status);
        while (status[15:8] != expCount && polls < 40) begin
            readReg(regStatus, status);
            polls++;
        end
        if (status[15:8] != expCount) begin
            $display("Completion count never reached %0d", expCount);
            timeouts++;
        end
    endtask

    task automatic runOp(input logic [31:0] a, input logic [31:0] b, input logic [3:0] op,
                         output logic [4:0] flagsGot);
        logic [36:0] expected;
        logic [31:0] status;
        logic [31:0] got;
        expected = referenceAlu(a, b, op);
        writeReg(regOpA, a);
        writeReg(regOpB, b);
        writeReg(regCtrl, {28'h0, op});
        expCount = expCount + 8'd1;
        waitDone(status);
        readReg(regResult, got);
        compareWord("regResult", expected[31:0], got);
        compareWord("flags", {27'h0, expected[36:32]}, {27'h0, status[4:0]});
        flagsGot   = status[4:0];
        lastResult = got;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [31:0] status;
        logic [36:0] expected;
        logic [4:0]  flagsGot;
        clk      = 1'b0;
        rst      = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        seed     = 32'd4405;
        errors   = 0;
        timeouts = 0;
        expCount = 8'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Legal opcodes, edge then random operands
        for (int op = 0; op < 10; op++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    runOp(edgeVals[i], edgeVals[j], op[3:0], flagsGot);
                end
            end
            for (int k = 0; k < 20; k++) begin
                a = nextRand();
                b = nextRand();
                runOp(a, b, op[3:0], flagsGot);
            end
        end

        runOp(32'h7FFF_FFFF, 32'h1, opAdd, flagsGot);
        compareWord("flags", 32'h0A, {27'h0, flagsGot});    // Negative and overflow
        runOp(32'h1234_5678, 32'h1234_5678, opSub, flagsGot);
        compareWord("flags", 32'h10, {27'h0, flagsGot});    // Equal operands, no borrow
        runOp(32'h8000_0000, 32'h1, opSll, flagsGot);
        compareWord("flags", 32'h10, {27'h0, flagsGot});

        // Mixed signs
        runOp(32'h8000_0000, 32'h1, opSlt, flagsGot);
        compareWord("regResult", 32'h1, lastResult);
        runOp(32'h8000_0000, 32'h1, opSltu, flagsGot);
        compareWord("regResult", 32'h0, lastResult);
        runOp(32'h7FFF_FFFF, 32'hFFFF_FFFF, opSlt, flagsGot);   // Difference overflows
        compareWord("regResult", 32'h0, lastResult);
        runOp(32'h7FFF_FFFF, 32'hFFFF_FFFF, opSltu, flagsGot);
        compareWord("regResult", 32'h1, lastResult);

        for (int op = 10; op < 16; op++) begin
            runOp(nextRand(), nextRand(), op[3:0], flagsGot);
            compareWord("flags", 32'h11, {27'h0, flagsGot});
        end

        // Three operations in flight
        writeReg(regOpA, 32'h1234_5678);
        writeReg(regOpB, 32'h0F0F_0F0F);
        writeReg(regCtrl, {28'h0, opAdd});
        writeReg(regCtrl, {28'h0, opSub});
        writeReg(regCtrl, {28'h0, opXor});
        expCount = expCount + 8'd3;
        waitDone(status);
        expected = referenceAlu(32'h1234_5678, 32'h0F0F_0F0F, opXor);
        readReg(regResult, got);
        compareWord("regResult", expected[31:0], got);
        lastResult = got;

        readReg(5'h14, got);
        compareWord("rdata", 32'h0, got);
        readReg(5'h1C, got);
        compareWord("rdata", 32'h0, got);
        writeReg(regResult, 32'hDEAD_BEEF);
        readReg(regResult, got);
        compareWord("regResult", lastResult, got);

        $display("Check errors: %0d, timeouts: %0d, checker failures: %0d",
                 errors, timeouts, aluTop_inst.checkerInst.failCount);
        if (errors == 0 && timeouts == 0 && aluTop_inst.checkerInst.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== claAdder.sv ====
`timescale 1ns/1ps
`default_nettype none

module claAdder (
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    input  logic                         subtract,
    output logic [aluPkg::dataWidth-1:0] sum,
    output logic                         carryOut,
    output logic                         overflow
);
    import aluPkg::*;

    logic [dataWidth-1:0] bInv;
    logic [dataWidth-1:0] prop;
    logic [dataWidth-1:0] gen;
    logic [dataWidth:0]   carry;    // carry[i] is the carry into bit i

    // Two's complement subtract
    assign bInv     = b ^ {dataWidth{subtract}};
    assign prop     = a ^ bInv;
    assign gen      = a & bInv;
    assign carry[0] = subtract;

    // Eight 4-bit lookahead groups, rippling between groups
    for (genvar g = 0; g < dataWidth / 4; g++) begin : genGroup
        logic [3:0] p;
        logic [3:0] gn;
        logic       cin;

        assign p   = prop[4*g +: 4];
        assign gn  = gen[4*g +: 4];
        assign cin = carry[4*g];

        assign carry[4*g+1] = gn[0] | (p[0] & cin);
        assign carry[4*g+2] = gn[1] | (p[1] & gn[0]) | (p[1] & p[0] & cin);
        assign carry[4*g+3] = gn[2] | (p[2] & gn[1]) | (p[2] & p[1] & gn[0])
                            | (p[2] & p[1] & p[0] & cin);
        // Group carry-out
        assign carry[4*g+4] = gn[3] | (p[3] & gn[2]) | (p[3] & p[2] & gn[1])
                            | (p[3] & p[2] & p[1] & gn[0])
                            | (p[3] & p[2] & p[1] & p[0] & cin);
    end

    assign sum      = prop ^ carry[dataWidth-1:0];
    assign carryOut = carry[dataWidth];   // Raw, not inverted for SUB
    // Carry into the sign bit against carry out of it
    assign overflow = carry[dataWidth-1] ^ carry[dataWidth];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f aluTop.f --top-module aluTop_tb -o aluSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/aluSim +verilator+error+limit+100)
simStatus=$?
echo "$output"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
